/* hdl/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    // Widths with a meaning
    typedef logic [63:0] xlen_t;     // Register and bus data
    typedef logic [31:0] pc_t;       // Instruction address
    typedef logic [31:0] instr_t;    // Instruction word
    typedef logic [4:0]  reg_idx_t;  // Register index

    // Data bus request, all fields driven from flops in the core
    typedef struct packed {
        xlen_t address;
        xlen_t write_data;
        logic  write_enable;  // One-cycle strobe
        logic  read_enable;   // One-cycle strobe
    } bus_req_t;

    typedef enum logic [1:0] {
        ST_RUN,        // Execute ir
        ST_FLUSH,      // Word in ir is stale after a redirect
        ST_LOAD_WAIT   // Second cycle of LD
    } core_state_t;

    localparam pc_t RESET_VECTOR = 32'd44;
    localparam pc_t ISR_VECTOR   = 32'd0;   // Fixed handler address

    localparam int    ROM_WORDS     = 64;
    localparam int    ROM_ADDR_BITS = $clog2(ROM_WORDS);
    localparam string ROM_FILE      = "program.hex";

    localparam xlen_t TX_ADDR       = 64'h0000_0000_8000_0000;  // Character out
    localparam int    RAM_WORDS     = 32;                       // Doublewords
    localparam int    RAM_ADDR_BITS = $clog2(RAM_WORDS);
    localparam xlen_t RAM_BASE      = 64'h0000_0000_0000_1000;

    // Major opcodes
    localparam logic [6:0] OP_LUI   = 7'b0110111;
    localparam logic [6:0] OP_OPIMM = 7'b0010011;
    localparam logic [6:0] OP_JAL   = 7'b1101111;
    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;

    localparam instr_t INSTR_MRET  = 32'h3020_0073;
    localparam instr_t INSTR_RESET = 32'h0000_0001;  // Matches no opcode

endpackage

`default_nettype wire

/* hdl/rv_regfile.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_regfile import rv_pkg::*; (
    input  logic     clk,
    input  logic     reset,    // Active low
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output xlen_t    rs1_data,
    output xlen_t    rs2_data,
    input  logic     rd_we,
    input  reg_idx_t rd,
    input  xlen_t    rd_data
);
    xlen_t regs [1:31];  // x0 has no storage

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (rd_we && (rd != '0)) begin
            regs[rd] <= rd_data;
        end
    end

    // Read ports, x0 reads as zero
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* hdl/instr_rom.sv */
`timescale 1ns/10ps
`default_nettype none

module instr_rom import rv_pkg::*; (
    input  pc_t    pc,
    output instr_t instruction
);
    instr_t rom [ROM_WORDS];

    // Program image, one word per line
    initial begin
        $readmemh(ROM_FILE, rom);
    end

    assign instruction = rom[pc[ROM_ADDR_BITS+1:2]];  // Word index

    // Upper pc bits must stay clear
    always_comb begin
        assert (pc < pc_t'(ROM_WORDS * 4))
            else $error("pc 0x%08h beyond instruction ROM", pc);
    end

endmodule

`default_nettype wire

/* hdl/bus_target.sv */
`timescale 1ns/10ps
`default_nettype none

module bus_target import rv_pkg::*; (
    input  logic       clk,
    input  logic       reset,          // Active low
    input  bus_req_t   bus_req,
    output xlen_t      bus_read_data,
    output logic       tx_valid,
    output logic [7:0] tx_data
);
    xlen_t                    ram [RAM_WORDS];
    logic                     in_ram;
    logic                     is_tx;
    logic [RAM_ADDR_BITS-1:0] ram_idx;

    // Address decode, RAM window is doubleword addressed
    assign in_ram  = (bus_req.address[63:RAM_ADDR_BITS+3]
                      == RAM_BASE[63:RAM_ADDR_BITS+3]);
    assign is_tx   = (bus_req.address == TX_ADDR);
    assign ram_idx = bus_req.address[RAM_ADDR_BITS+2:3];

    // RAM and character payload
    always_ff @(posedge clk) begin
        if (bus_req.write_enable && in_ram)
            ram[ram_idx] <= bus_req.write_data;
        if (bus_req.write_enable && is_tx)
            tx_data <= bus_req.write_data[7:0];   // Low byte only
    end

    // Character strobe, one cycle per write
    always_ff @(posedge clk or negedge reset) begin
        if (!reset)
            tx_valid <= 1'b0;
        else
            tx_valid <= bus_req.write_enable && is_tx;
    end

    // Data valid in the strobe cycle, one cycle after LD issues it
    // Unmapped reads return zero
    assign bus_read_data = (bus_req.read_enable && in_ram) ? ram[ram_idx] : '0;

endmodule

`default_nettype wire

/* hdl/rv_core.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_core import rv_pkg::*; (
    input  logic     clk,
    input  logic     reset,          // Active low
    input  logic     irq,            // External interrupt, edge triggered
    input  instr_t   instruction,    // ROM word at pc
    output pc_t      pc,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    input  xlen_t    rs1_data,
    input  xlen_t    rs2_data,
    output logic     rd_we,
    output reg_idx_t rd,
    output xlen_t    rd_data,
    output bus_req_t bus_req,
    input  xlen_t    bus_read_data,
    output logic     heartbeat,
    output logic     interrupt_pending,
    output logic     interrupt_done
);
    instr_t      ir;
    core_state_t state;
    pc_t         mepc;       // Return address for MRET
    pc_t         ir_pc;      // Address of the word in ir
    logic        irq_q;
    logic        irq_req;    // Edge seen, entry not yet taken
    logic        take_irq;
    logic        exec;       // ir is live this cycle
    logic        is_lui;
    logic        is_addi;
    logic        is_jal;
    logic        is_load;
    logic        is_store;
    logic        is_mret;
    xlen_t       imm_i;
    xlen_t       imm_s;
    xlen_t       imm_u;
    xlen_t       imm_j;

    // Immediates, all sign extended from ir[31]
    assign imm_i = {{52{ir[31]}}, ir[31:20]};
    assign imm_s = {{52{ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_u = {{32{ir[31]}}, ir[31:12], 12'b0};
    assign imm_j = {{44{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};

    assign is_lui   = (ir[6:0] == OP_LUI);
    assign is_addi  = (ir[6:0] == OP_OPIMM);
    assign is_jal   = (ir[6:0] == OP_JAL);
    assign is_load  = (ir[6:0] == OP_LOAD);   // LD only
    assign is_store = (ir[6:0] == OP_STORE);  // SD only
    assign is_mret  = (ir == INSTR_MRET);

    assign rs1 = ir[19:15];
    assign rs2 = ir[24:20];
    assign rd  = ir[11:7];   // ir still holds LD during ST_LOAD_WAIT

    assign ir_pc    = pc - 32'd4;  // pc already one word ahead
    assign take_irq = irq_req && !interrupt_pending && (state != ST_LOAD_WAIT);
    assign exec     = (state == ST_RUN) && !take_irq;  // Entry wins over ir

    // Write-back value
    always_comb begin
        if (state == ST_LOAD_WAIT)
            rd_data = bus_read_data;      // LD result
        else if (is_lui)
            rd_data = imm_u;
        else if (is_jal)
            rd_data = xlen_t'(pc);        // Link = JAL address + 4
        else
            rd_data = rs1_data + imm_i;   // ADDI
    end

    assign rd_we = (rd != '0)
                && ((exec && (is_lui || is_addi || is_jal)) || (state == ST_LOAD_WAIT));

    // Fetch register, pc, state machine, bus request
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc                <= RESET_VECTOR;
            ir                <= INSTR_RESET;
            state             <= ST_RUN;
            mepc              <= '0;
            bus_req           <= '0;
            interrupt_pending <= 1'b0;
            interrupt_done    <= 1'b0;
        end else begin
            // Defaults: strobes drop, fetch steps on
            bus_req.write_enable <= 1'b0;
            bus_req.read_enable  <= 1'b0;
            interrupt_done       <= 1'b0;
            pc                   <= pc + 32'd4;
            ir                   <= instruction;
            state                <= ST_RUN;

            if (take_irq) begin
                // Resume at the word that did not run
                mepc              <= (state == ST_RUN) ? ir_pc : pc;
                pc                <= ISR_VECTOR;
                state             <= ST_FLUSH;
                interrupt_pending <= 1'b1;
            end else if (exec) begin
                if (is_jal) begin
                    pc    <= ir_pc + imm_j[31:0];
                    state <= ST_FLUSH;
                end else if (is_mret) begin
                    pc                <= mepc;
                    state             <= ST_FLUSH;
                    interrupt_pending <= 1'b0;
                    interrupt_done    <= 1'b1;   // Single pulse
                end else if (is_load) begin
                    pc                  <= pc;   // Hold fetch for one cycle
                    ir                  <= ir;
                    bus_req.address     <= rs1_data + imm_i;
                    bus_req.read_enable <= 1'b1;
                    state               <= ST_LOAD_WAIT;
                end else if (is_store) begin
                    bus_req.address      <= rs1_data + imm_s;
                    bus_req.write_data   <= rs2_data;
                    bus_req.write_enable <= 1'b1;
                end
            end
        end
    end

    // Heartbeat and irq edge capture
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            heartbeat <= 1'b0;
            irq_q     <= 1'b0;
            irq_req   <= 1'b0;
        end else begin
            heartbeat <= ~heartbeat;
            irq_q     <= irq;
            if (take_irq)
                irq_req <= 1'b0;
            else if (irq && !irq_q && !interrupt_pending)
                irq_req <= 1'b1;   // Edges inside the handler are dropped
        end
    end

    a_one_strobe: assert property (@(posedge clk) disable iff (!reset)
        !(bus_req.write_enable && bus_req.read_enable))
        else $error("Bus read and write strobes together");

    // MRET only from inside the handler
    a_done_after_pending: assert property (@(posedge clk) disable iff (!reset)
        interrupt_done |-> $past(interrupt_pending))
        else $error("interrupt_done without a pending interrupt");

endmodule

`default_nettype wire

/* hdl/rv_mini_top.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_mini_top import rv_pkg::*; (
    input  logic       clk,
    input  logic       reset,              // Active low
    input  logic       irq,
    output logic       heartbeat,
    output logic       interrupt_pending,
    output logic       interrupt_done,
    output logic       tx_valid,
    output logic [7:0] tx_data
);
    pc_t      pc;
    instr_t   instruction;
    reg_idx_t rs1;
    reg_idx_t rs2;
    xlen_t    rs1_data;
    xlen_t    rs2_data;
    logic     rd_we;
    reg_idx_t rd;
    xlen_t    rd_data;
    bus_req_t bus_req;
    xlen_t    bus_read_data;

    rv_core i_core (
        .clk, .reset, .irq,
        .instruction, .pc,
        .rs1, .rs2, .rs1_data, .rs2_data,
        .rd_we, .rd, .rd_data,
        .bus_req, .bus_read_data,
        .heartbeat, .interrupt_pending, .interrupt_done
    );

    rv_regfile i_regfile (
        .clk, .reset,
        .rs1, .rs2, .rs1_data, .rs2_data,
        .rd_we, .rd, .rd_data
    );

    instr_rom i_rom (.pc, .instruction);

    bus_target i_bus (.clk, .reset, .bus_req, .bus_read_data, .tx_valid, .tx_data);

endmodule

`default_nettype wire

/* tests/tb_rv_mini.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_rv_mini;
    parameter int SEED = 97869;

    localparam int CH_BANG = 'h21;  // '!'
    localparam int CH_L    = 'h4C;  // 'L'
    localparam int MAIN_CHARS [6] = '{'h4F, 'h4B, 'h52, 'h4C, 'h4C, 'h4C};  // O K R L L L

    logic       clk;
    logic       reset;
    logic       irq;
    logic       heartbeat;
    logic       interrupt_pending;
    logic       interrupt_done;
    logic       tx_valid;
    logic [7:0] tx_data;

    logic [7:0] chars [$];         // Character stream from the TX port
    int         done_count   = 0;  // interrupt_done pulses seen
    int         test_errors  = 0;
    int         total_errors = 0;
    int         tests_run    = 0;
    int         tests_failed = 0;
    string      test_name    = "";

    rv_mini_top i_dut (
        .clk, .reset, .irq, .heartbeat, .interrupt_pending,
        .interrupt_done, .tx_valid, .tx_data
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    // Mid-cycle capture, well away from the rising edge
    always @(negedge clk) begin
        if (reset && tx_valid)
            chars.push_back(tx_data);
        if (reset && interrupt_done)
            done_count++;  // A stretched pulse counts twice
    end

    // Hard stop if a wait never returns
    initial begin
        #20000;
        $display("Simulation stopped at its time limit");
        $display("Test failed");
        $finish;
    end

    heartbeat_toggles: assert property (@(posedge clk) disable iff (!reset)
        $past(reset) |-> (heartbeat != $past(heartbeat)))
        else begin
            $display("%s: heartbeat did not toggle at %0t", test_name, $time);
            note_error();
        end

    // MRET drops pending on the same edge that raises done
    done_clears_pending: assert property (@(posedge clk) disable iff (!reset)
        interrupt_done |-> (!interrupt_pending && $past(interrupt_pending)))
        else begin
            $display("%s: interrupt_done without pending falling at %0t", test_name, $time);
            note_error();
        end

    task automatic note_error();
        test_errors++;
        total_errors++;
    endtask

    task automatic start_test(string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("%-12s ok", test_name);
        end else begin
            tests_failed++;
            $display("%-12s %0d error(s)", test_name, test_errors);
        end
    endtask

    task automatic expect_value(string what, int expected, int actual);
        assert (actual == expected)
            else begin
                $display("FAILED %s %s: expected 0x%0h, got 0x%0h",
                         test_name, what, expected, actual);
                note_error();
            end
    endtask

    function automatic int count_char(int c, int from);
        int total = 0;
        for (int i = from; i < chars.size(); i++)
            if (int'(chars[i]) == c)
                total++;
        return total;
    endfunction

    // Queue only grows at negedge, so polling on posedge is race free
    task automatic wait_for_chars(int count, int limit);
        int n = 0;
        while (chars.size() < count && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (chars.size() < count) begin
            $display("%s: only %0d of %0d characters arrived", test_name, chars.size(), count);
            note_error();
        end
    endtask

    // Entry then MRET, each with its own timeout
    task automatic wait_for_irq_cycle(int limit);
        int n = 0;
        while (interrupt_pending !== 1'b1 && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (interrupt_pending !== 1'b1) begin
            $display("%s: interrupt_pending never rose after the irq edge", test_name);
            note_error();
        end
        n = 0;
        while (interrupt_done !== 1'b1 && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (interrupt_done !== 1'b1) begin
            $display("%s: interrupt_done never pulsed", test_name);
            note_error();
        end else begin
            expect_value("pending at done", 0, int'(interrupt_pending));
        end
        @(posedge clk);  // Back on the edge, queue settled
    endtask

    initial begin
        int base;
        int delay;
        logic hb;
        void'($urandom(SEED));
        reset = 1'b0;
        irq   = 1'b0;

        start_test("after_reset");
        repeat (3) @(posedge clk);
        @(negedge clk);  // Still inside reset
        expect_value("pending", 0, int'(interrupt_pending));
        expect_value("done", 0, int'(interrupt_done));
        expect_value("tx_valid", 0, int'(tx_valid));
        expect_value("heartbeat", 0, int'(heartbeat));
        @(posedge clk);
        #1 reset = 1'b1;  // Fourth edge done
        @(negedge clk);
        hb = heartbeat;
        repeat (4) begin
            @(negedge clk);
            expect_value("heartbeat", int'(!hb), int'(heartbeat));
            hb = heartbeat;
        end
        end_test();

        start_test("main_stream");
        wait_for_chars(6, 200);
        for (int i = 0; i < 6; i++)
            expect_value($sformatf("char %0d", i), MAIN_CHARS[i], int'(chars[i]));
        expect_value("pending", 0, int'(interrupt_pending));
        end_test();

        start_test("irq_entry");
        delay = int'($urandom_range(12, 1));
        repeat (delay) @(posedge clk);
        #1 irq = 1'b1;  // Held high from here on
        base = chars.size();
        wait_for_irq_cycle(40);
        expect_value("'!' count", 1, count_char(CH_BANG, base));
        expect_value("'L' count", chars.size() - base - 1, count_char(CH_L, base));
        end_test();

        start_test("irq_return");
        wait_for_chars(chars.size() + 3, 40);  // Resumed loop output
        expect_value("done pulses", 1, done_count);
        expect_value("pending after MRET", 0, int'(interrupt_pending));
        expect_value("'!' count", 1, count_char(CH_BANG, base));
        expect_value("'L' count", chars.size() - base - 1, count_char(CH_L, base));
        end_test();

        start_test("no_reentry");
        repeat (40) begin
            @(negedge clk);
            expect_value("pending with irq held", 0, int'(interrupt_pending));
        end
        expect_value("'!' count with irq held", 1, count_char(CH_BANG, base));
        @(posedge clk);
        #1 irq = 1'b0;
        repeat (4) @(posedge clk);
        #1 irq = 1'b1;  // Second rising edge
        wait_for_irq_cycle(40);
        wait_for_chars(chars.size() + 3, 40);
        expect_value("'!' count after new edge", 2, count_char(CH_BANG, base));
        expect_value("done pulses", 2, done_count);
        @(posedge clk);
        #1 irq = 1'b0;
        end_test();

        $display("Summary: %0d tests, %0d failed, %0d errors",
                 tests_run, tests_failed, total_errors);
        if (total_errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* rv_mini.f */
hdl/rv_pkg.sv
hdl/rv_regfile.sv
hdl/instr_rom.sv
hdl/bus_target.sv
hdl/rv_core.sv
hdl/rv_mini_top.sv
tests/tb_rv_mini.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rv_mini
FILELIST  ?= rv_mini.f
SEED      ?= 97869
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST SEED BUILD_DIR"

test:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		-GSEED=$(SEED) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(BUILD_DIR)

/* program.hex */
// One 32-bit instruction word per line in hex, starting at word 0
// Handler at 0x00, main code from 0x2c (word 0x0b)
7ffff537  // lui  x10, 0x7ffff
7ff50513  // addi x10, x10, 2047
7ff50513  // addi x10, x10, 2047
00250513  // addi x10, x10, 2     x10 = TX_ADDR
02100593  // addi x11, x0, '!'
00b53023  // sd   x11, 0(x10)
30200073  // mret
@0b
7ffff0b7  // lui  x1, 0x7ffff
7ff08093  // addi x1, x1, 2047
7ff08093  // addi x1, x1, 2047
00208093  // addi x1, x1, 2       x1 = TX_ADDR
04f00113  // addi x2, x0, 'O'
0020b023  // sd   x2, 0(x1)
04b00113  // addi x2, x0, 'K'
0020b023  // sd   x2, 0(x1)
000011b7  // lui  x3, 0x1         RAM base
05200213  // addi x4, x0, 'R'
0041b423  // sd   x4, 8(x3)
0081b283  // ld   x5, 8(x3)
0050b023  // sd   x5, 0(x1)       loaded 'R' out
04c00113  // addi x2, x0, 'L'
0020b023  // sd   x2, 0(x1)       loop head at 0x64
ffdff06f  // jal  x0, -4
